/* Makefile */
# Verilator build and run of the floor request controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module tb_floor_logic -Mdir obj_dir -o tb_floor_logic
	./obj_dir/tb_floor_logic | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* call_register.sv */
// Presses at the car's own floor are dropped; lamps hold their value while service_enable is low
`timescale 1ns/100ps
`default_nettype none

`include "floor_logic_macros.svh"

module call_register (
    input  logic                        clock,
    input  logic                        reset_n,
    input  floor_logic_pkg::floor_mask_t buttons,
    input  floor_logic_pkg::car_status_t car,
    input  logic                        service_enable,
    output floor_logic_pkg::floor_mask_t lamps
);

    // One-hot mask of the floor the car is at
    floor_logic_pkg::floor_mask_t here_mask;
    // Requests to add this cycle
    floor_logic_pkg::floor_mask_t set_mask;
    // Requests served this cycle
    floor_logic_pkg::floor_mask_t clear_mask;
    floor_logic_pkg::floor_mask_t lamps_next;

    ////////////////////////////////////////
    // Current floor decode
    ////////////////////////////////////////

    always_comb begin
        here_mask = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            here_mask[i] = (car.floor == floor_logic_pkg::floor_t'(i));
        end
    end

    ////////////////////////////////////////
    // Lamp update
    ////////////////////////////////////////

    // A press at the current floor is already served, so it never lights
    assign set_mask = buttons & ~here_mask;

    // Only a stopped car serves its floor; passing through does not count
    assign clear_mask = car.moving ? '0 : here_mask;

    // Clear wins over set, though the two masks never overlap anyway
    assign lamps_next = (lamps | set_mask) & ~clear_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else if (service_enable) begin
            lamps <= lamps_next;
        end
    end

endmodule

`default_nettype wire

/* dispatch_control.sv */
// State lags power and emergency by one edge; outputs are registered one cycle behind their causes
`timescale 1ns/100ps
`default_nettype none

module dispatch_control (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          power_switch,
    input  logic                          emergency_button,
    input  logic                          door_open_button,
    input  logic                          door_close_button,
    input  floor_logic_pkg::car_status_t  car,
    input  floor_logic_pkg::floor_t       next_target,
    output logic                          service_enable,
    output floor_logic_pkg::dispatch_t    dispatch,
    output floor_logic_pkg::door_permit_t door
);

    floor_logic_pkg::dispatch_state_t state;
    floor_logic_pkg::dispatch_state_t state_next;
    floor_logic_pkg::dispatch_t       dispatch_next;
    floor_logic_pkg::door_permit_t    door_next;

    // Car stopped and controller running
    logic serviceable;
    logic halt_request;

    ////////////////////////////////////////
    // Status decode
    ////////////////////////////////////////

    assign halt_request   = !power_switch || emergency_button;
    assign service_enable = (state != floor_logic_pkg::halted);
    assign serviceable    = service_enable && !car.moving;

    ////////////////////////////////////////
    // Dispatch and door decisions
    ////////////////////////////////////////

    always_comb begin
        dispatch_next = dispatch;

        // Target tracks the selector on every edge, even while halted
        dispatch_next.target   = next_target;
        dispatch_next.activate = serviceable && (next_target != car.floor);

        // Direction only changes when a move is actually requested
        if (dispatch_next.activate) begin
            dispatch_next.up = (next_target > car.floor);
        end

        if (serviceable) begin
            door_next.open_allowed  = door_open_button;
            door_next.close_allowed = door_close_button;
        end else begin
            door_next = '0;
        end
    end

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        if (halt_request) begin
            state_next = floor_logic_pkg::halted;
        end else if (dispatch_next.activate) begin
            state_next = floor_logic_pkg::dispatching;
        end else begin
            state_next = floor_logic_pkg::idle;
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= floor_logic_pkg::halted;
            dispatch <= '0;
            door     <= '0;
        end else begin
            state    <= state_next;
            dispatch <= dispatch_next;
            door     <= door_next;
        end
    end

endmodule

`default_nettype wire

/* floor_logic_assertions.sv */
// Checks sample on the rising clock edge; a stopped car is assumed one cycle before every dispatch
`timescale 1ns/100ps
`default_nettype none

module floor_logic_assertions (
    input logic                          clock,
    input logic                          reset_n,
    input floor_logic_pkg::car_status_t  car,
    input floor_logic_pkg::floor_mask_t  hall_lamps,
    input floor_logic_pkg::floor_mask_t  cab_lamps,
    input floor_logic_pkg::dispatch_t    dispatch,
    input floor_logic_pkg::door_permit_t door
);

    // Count of fired assertions, read by the testbench at the end
    int failure_count = 0;

    ////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////

    reset_outputs_zero: assert property (@(posedge clock)
        !reset_n |-> (hall_lamps == '0 && cab_lamps == '0 && dispatch == '0 && door == '0))
    else begin
        $error("outputs not zero during reset");
        failure_count++;
    end

    ////////////////////////////////////////
    // Motion and doors
    ////////////////////////////////////////

    // Dispatch only issues to a car that stood still
    activate_from_stop: assert property (@(posedge clock) disable iff (!reset_n)
        dispatch.activate |-> !$past(car.moving))
    else begin
        $error("activate raised while the car was moving");
        failure_count++;
    end

    door_closed_when_moving: assert property (@(posedge clock) disable iff (!reset_n)
        car.moving |=> (door == '0))
    else begin
        $error("door permit granted after the car moved");
        failure_count++;
    end

endmodule

bind floor_logic_top floor_logic_assertions floor_logic_assertions_inst (
    .clock      (clock),
    .reset_n    (reset_n),
    .car        (car),
    .hall_lamps (hall_lamps),
    .cab_lamps  (cab_lamps),
    .dispatch   (dispatch),
    .door       (door)
);

`default_nettype wire

/* floor_logic_macros.svh */
// Sized for an eleven-floor shaft; FLOOR_WIDTH must cover FLOOR_COUNT-1 when either changes
`ifndef FLOOR_LOGIC_MACROS_SVH
`define FLOOR_LOGIC_MACROS_SVH

////////////////////////////////////////
// Shaft geometry
////////////////////////////////////////

// Number of landings served by the car, floor 1 is index 0
`define FLOOR_COUNT 11

// Bits in a floor index
`define FLOOR_WIDTH 4

`endif

/* floor_logic_pkg.sv */
// Floor indices are zero based (floor 1 is 0); struct field order fixes the packed bit layout
`default_nettype none

`include "floor_logic_macros.svh"

package floor_logic_pkg;

    ////////////////////////////////////////
    // Floor types
    ////////////////////////////////////////

    // One floor index, 0 up to FLOOR_COUNT-1
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Position reported by the car's motion FSM
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Command to the motion FSM
    typedef struct packed {
        floor_t target;
        logic   up;       // 1 = travel up, 0 = travel down
        logic   activate;
    } dispatch_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

    // Dispatcher FSM
    typedef enum logic [1:0] {
        halted,
        idle,
        dispatching
    } dispatch_state_t;

endpackage

`default_nettype wire

/* floor_logic_top.sv */
// The motion FSM is external; car status must come from it and dispatch drives it, no handshake
`timescale 1ns/100ps
`default_nettype none

module floor_logic_top (
    input  logic                          clock,
    input  logic                          reset_n,
    input  floor_logic_pkg::floor_mask_t  hall_buttons,
    input  floor_logic_pkg::floor_mask_t  cab_buttons,
    input  floor_logic_pkg::car_status_t  car,
    input  logic                          door_open_button,
    input  logic                          door_close_button,
    input  logic                          emergency_button,
    input  logic                          power_switch,
    output floor_logic_pkg::floor_mask_t  hall_lamps,
    output floor_logic_pkg::floor_mask_t  cab_lamps,
    output floor_logic_pkg::dispatch_t    dispatch,
    output floor_logic_pkg::door_permit_t door
);

    // Union of both banks, the set of floors still to visit
    floor_logic_pkg::floor_mask_t pending;
    floor_logic_pkg::floor_t      next_target;
    logic                         service_enable;

    ////////////////////////////////////////
    // Request banks
    ////////////////////////////////////////

    call_register hall_register (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (hall_buttons),
        .car            (car),
        .service_enable (service_enable),
        .lamps          (hall_lamps)
    );

    call_register cab_register (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (cab_buttons),
        .car            (car),
        .service_enable (service_enable),
        .lamps          (cab_lamps)
    );

    assign pending = hall_lamps | cab_lamps;

    ////////////////////////////////////////
    // Target choice and dispatcher
    ////////////////////////////////////////

    // Direction fed back from the registered dispatch
    target_selector target_selector_inst (
        .pending       (pending),
        .current_floor (car.floor),
        .travel_up     (dispatch.up),
        .next_target   (next_target)
    );

    dispatch_control dispatch_control_inst (
        .clock             (clock),
        .reset_n           (reset_n),
        .power_switch      (power_switch),
        .emergency_button  (emergency_button),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .car               (car),
        .next_target       (next_target),
        .service_enable    (service_enable),
        .dispatch          (dispatch),
        .door              (door)
    );

endmodule

`default_nettype wire

/* target_selector.sv */
// Purely combinational; with no lamp lit the target is the current floor, so no move results
`timescale 1ns/100ps
`default_nettype none

`include "floor_logic_macros.svh"

module target_selector (
    input  floor_logic_pkg::floor_mask_t pending,
    input  floor_logic_pkg::floor_t      current_floor,
    input  logic                        travel_up,
    output floor_logic_pkg::floor_t      next_target
);

    // Lowest and highest lit floors
    floor_logic_pkg::floor_t lowest_lit;
    floor_logic_pkg::floor_t highest_lit;
    logic                    any_lit;

    ////////////////////////////////////////
    // Priority search
    ////////////////////////////////////////

    // Scan from the top down so the last hit is the lowest lit floor
    always_comb begin
        lowest_lit = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest_lit = floor_logic_pkg::floor_t'(i);
            end
        end
    end

    // Scan from the bottom up so the last hit is the highest lit floor
    always_comb begin
        highest_lit = '0;
        for (int i = 0; i < `FLOOR_COUNT; i++) begin
            if (pending[i]) begin
                highest_lit = floor_logic_pkg::floor_t'(i);
            end
        end
    end

    assign any_lit = |pending;

    ////////////////////////////////////////
    // Direction select
    ////////////////////////////////////////

    always_comb begin
        if (!any_lit) begin
            next_target = current_floor;
        end else if (travel_up) begin
            next_target = lowest_lit;
        end else begin
            next_target = highest_lit;
        end
    end

endmodule

`default_nettype wire

/* tb_floor_logic.sv */
// Directed tests with a simple car model; the car starts stopped at floor 1 after each reset
`timescale 1ns/100ps
`default_nettype none

`include "floor_logic_macros.svh"

module tb_floor_logic;

    // The tests need about 125 cycles at most, so this leaves wide margin
    localparam int watchdog_cycles  = 400;
    localparam int cycles_per_floor = 3;

    logic                          clock;
    logic                          reset_n;
    floor_logic_pkg::floor_mask_t  hall_buttons;
    floor_logic_pkg::floor_mask_t  cab_buttons;
    floor_logic_pkg::car_status_t  car;
    logic                          door_open_button;
    logic                          door_close_button;
    logic                          emergency_button;
    logic                          power_switch;
    floor_logic_pkg::floor_mask_t  hall_lamps;
    floor_logic_pkg::floor_mask_t  cab_lamps;
    floor_logic_pkg::dispatch_t    dispatch;
    floor_logic_pkg::door_permit_t door;
    integer                        seed;

    floor_logic_top floor_logic_top_inst (
        .clock             (clock),
        .reset_n           (reset_n),
        .hall_buttons      (hall_buttons),
        .cab_buttons       (cab_buttons),
        .car               (car),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency_button  (emergency_button),
        .power_switch      (power_switch),
        .hall_lamps        (hall_lamps),
        .cab_lamps         (cab_lamps),
        .dispatch          (dispatch),
        .door              (door)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Expected value helpers
    ////////////////////////////////////////

    function automatic floor_logic_pkg::floor_mask_t floor_bit(input floor_logic_pkg::floor_t f);
        return floor_logic_pkg::floor_mask_t'(1) << f;
    endfunction

    function automatic floor_logic_pkg::dispatch_t dispatch_word(
        input floor_logic_pkg::floor_t target,
        input logic up,
        input logic activate
    );
        floor_logic_pkg::dispatch_t d;
        d.target   = target;
        d.up       = up;
        d.activate = activate;
        return d;
    endfunction

    function automatic floor_logic_pkg::door_permit_t door_word(input logic open, input logic close);
        floor_logic_pkg::door_permit_t p;
        p.open_allowed  = open;
        p.close_allowed = close;
        return p;
    endfunction

    ////////////////////////////////////////
    // Result checks
    ////////////////////////////////////////

    task automatic mask_check(
        input string name,
        input floor_logic_pkg::floor_mask_t actual,
        input floor_logic_pkg::floor_mask_t expected
    );
        if (actual !== expected) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic dispatch_check(input floor_logic_pkg::dispatch_t expected);
        if (dispatch !== expected) begin
            $display({"FAIL %0t dispatch expected target %0d up %b activate %b",
                      " actual target %0d up %b activate %b"},
                     $time, expected.target, expected.up, expected.activate,
                     dispatch.target, dispatch.up, dispatch.activate);
            $display("test failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic door_check(input floor_logic_pkg::door_permit_t expected);
        if (door !== expected) begin
            $display("FAIL %0t door expected %b actual %b", $time, expected, door);
            $display("test failed");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and car model
    ////////////////////////////////////////

    // Drives every input to its idle value, power off
    task automatic apply_reset();
        reset_n           = 1'b0;
        hall_buttons      = '0;
        cab_buttons       = '0;
        car               = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
        power_switch      = 1'b0;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;
    endtask

    // State leaves halted one edge after power rises
    task automatic power_on();
        power_switch = 1'b1;
        @(negedge clock);
    endtask

    // Latches the target when activate is seen, then steps one floor per few cycles
    task automatic run_car();
        floor_logic_pkg::floor_t goal;
        while (!dispatch.activate) begin
            @(negedge clock);
        end
        goal       = dispatch.target;
        car.moving = 1'b1;
        while (car.floor != goal) begin
            repeat (cycles_per_floor) @(negedge clock);
            if (goal > car.floor) begin
                car.floor = car.floor + 1'b1;
            end else begin
                car.floor = car.floor - 1'b1;
            end
        end
        car.moving = 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_state_test();
        apply_reset();
        mask_check("hall_lamps", hall_lamps, '0);
        mask_check("cab_lamps", cab_lamps, '0);
        dispatch_check(dispatch_word('0, 1'b0, 1'b0));
        door_check(door_word(1'b0, 1'b0));
    endtask

    task automatic lamp_latch_test();
        apply_reset();
        power_on();
        // Floor 1 presses land on the car's own floor
        hall_buttons = floor_bit(4'd3) | floor_bit(4'd0);
        cab_buttons  = floor_bit(4'd5) | floor_bit(4'd0);
        @(negedge clock);
        hall_buttons = '0;
        cab_buttons  = '0;
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd3));
        mask_check("cab_lamps", cab_lamps, floor_bit(4'd5));
        @(negedge clock);
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd3));
        mask_check("cab_lamps", cab_lamps, floor_bit(4'd5));
    endtask

    task automatic travel_test();
        int                      low_pick;
        int                      high_pick;
        floor_logic_pkg::floor_t low_floor;
        floor_logic_pkg::floor_t high_floor;
        low_pick   = 1 + ({$random(seed)} % 5);
        high_pick  = low_pick + 1 + ({$random(seed)} % (`FLOOR_COUNT - 1 - low_pick));
        low_floor  = floor_logic_pkg::floor_t'(low_pick);
        high_floor = floor_logic_pkg::floor_t'(high_pick);
        apply_reset();
        power_on();
        hall_buttons = floor_bit(low_floor) | floor_bit(high_floor);
        cab_buttons  = floor_bit(high_floor);
        @(negedge clock);
        hall_buttons = '0;
        cab_buttons  = '0;
        mask_check("hall_lamps", hall_lamps, floor_bit(low_floor) | floor_bit(high_floor));
        mask_check("cab_lamps", cab_lamps, floor_bit(high_floor));
        // Down after reset, so the highest lit floor wins
        @(negedge clock);
        dispatch_check(dispatch_word(high_floor, 1'b1, 1'b1));
        run_car();
        @(negedge clock);
        mask_check("hall_lamps", hall_lamps, floor_bit(low_floor));
        mask_check("cab_lamps", cab_lamps, '0);
        // Up is set now, so the lowest lit floor is next
        dispatch_check(dispatch_word(low_floor, 1'b0, 1'b1));
        run_car();
        @(negedge clock);
        mask_check("hall_lamps", hall_lamps, '0);
        mask_check("cab_lamps", cab_lamps, '0);
        dispatch_check(dispatch_word(low_floor, 1'b0, 1'b0));
    endtask

    task automatic halt_test();
        apply_reset();
        power_on();
        hall_buttons     = floor_bit(4'd4);
        emergency_button = 1'b1;
        @(negedge clock);
        // Halt takes hold one edge late, so this press still landed
        hall_buttons = floor_bit(4'd2);
        cab_buttons  = floor_bit(4'd7);
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd4));
        @(negedge clock);
        hall_buttons = '0;
        cab_buttons  = '0;
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd4));
        mask_check("cab_lamps", cab_lamps, '0);
        dispatch_check(dispatch_word(4'd4, 1'b0, 1'b0));
        // A stopped car at a lit floor clears nothing while halted
        car.floor = 4'd4;
        repeat (3) @(negedge clock);
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd4));
        dispatch_check(dispatch_word(4'd4, 1'b0, 1'b0));
        emergency_button = 1'b0;
        power_switch     = 1'b0;
        cab_buttons      = floor_bit(4'd7);
        // The first edge still sees the emergency halt, the second only power off
        repeat (2) @(negedge clock);
        cab_buttons = '0;
        mask_check("cab_lamps", cab_lamps, '0);
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd4));
        power_on();
        mask_check("hall_lamps", hall_lamps, floor_bit(4'd4));
        @(negedge clock);
        mask_check("hall_lamps", hall_lamps, '0);
        dispatch_check(dispatch_word(4'd4, 1'b0, 1'b0));
    endtask

    task automatic door_test();
        apply_reset();
        power_on();
        door_open_button = 1'b1;
        @(negedge clock);
        door_check(door_word(1'b1, 1'b0));
        door_open_button  = 1'b0;
        door_close_button = 1'b1;
        @(negedge clock);
        door_check(door_word(1'b0, 1'b1));
        car.moving = 1'b1;
        @(negedge clock);
        door_check(door_word(1'b0, 1'b0));
        car.moving       = 1'b0;
        door_open_button = 1'b1;
        emergency_button = 1'b1;
        @(negedge clock);
        door_check(door_word(1'b1, 1'b1));
        @(negedge clock);
        door_check(door_word(1'b0, 1'b0));
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
    endtask

    initial begin
        seed = 32'hcf158e66;
        reset_state_test();
        lamp_latch_test();
        travel_test();
        halt_test();
        door_test();
        if (floor_logic_top_inst.floor_logic_assertions_inst.failure_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "bound assertions reported errors");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
floor_logic_pkg.sv
call_register.sv
target_selector.sv
dispatch_control.sv
floor_logic_top.sv
floor_logic_assertions.sv
tb_floor_logic.sv
